// ==== rtl/ex_params.svh ====
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// data path width
`define EX_XLEN 32

// alu function codes
`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_SLT  4'd2
`define ALU_SLTU 4'd3
`define ALU_AND  4'd4
`define ALU_NOR  4'd5
`define ALU_OR   4'd6
`define ALU_XOR  4'd7
`define ALU_SLL  4'd8
`define ALU_SRL  4'd9
`define ALU_SRA  4'd10
`define ALU_LUI  4'd11

// operation kinds that pick the unit
`define KIND_ALU 3'd0
`define KIND_BR  3'd1
`define KIND_DIV 3'd2
`define KIND_LD  3'd3
`define KIND_ST  3'd4

// memory access widths
`define MW_B 2'd0
`define MW_H 2'd1
`define MW_W 2'd2

// one quotient bit per step
`define DIV_STEPS 32

`endif

// ==== rtl/ex_pkg.sv ====
`default_nettype none

`include "ex_params.svh"

package ex_pkg;

  // plain vector types
  typedef logic [`EX_XLEN-1:0]     word_t;
  typedef logic [3:0]              alu_op_t;
  typedef logic [2:0]              ex_kind_t;
  typedef logic [1:0]              mem_width_t;
  typedef logic [`EX_XLEN/8-1:0]   strb_t;

  // branch decode bits from the issue side
  typedef struct packed {
    logic may_jump;
    logic use_less;
    logic need_less;
    logic use_zero;
    logic need_zero;
    // target base is rj, otherwise pc
    logic use_rj;
    logic pre_jump;
  } br_ctl_t;

  // one issued operation
  typedef struct packed {
    ex_kind_t   kind;
    alu_op_t    alu_op;
    word_t      src1;
    word_t      src2;
    word_t      imm;
    word_t      pc;
    mem_width_t mem_width;
    logic       is_unsigned;
    logic       use_mod;
    br_ctl_t    br;
  } ex_req_t;

  // registered result of one operation
  typedef struct packed {
    word_t result;
    logic  excp_ale;
    logic  need_jump;
    word_t jump_target;
    logic  pre_fail;
  } ex_res_t;

  // data cache request side
  typedef struct packed {
    logic  valid;
    logic  we;
    word_t addr;
    strb_t strb;
    word_t wdata;
  } dcache_req_t;

  // data cache response side
  typedef struct packed {
    logic  ready;
    logic  rvalid;
    word_t rdata;
  } dcache_resp_t;

  // controller states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_DIV,
    ST_MEM_REQ,
    ST_MEM_DATA,
    ST_DONE
  } ex_state_t;

endpackage

`default_nettype wire

// ==== rtl/ex_alu.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_params.svh"

module ex_alu
  import ex_pkg::*;
(
  input  alu_op_t alu_op,
  input  word_t   src1,
  input  word_t   src2,
  output word_t   result,
  output logic    less,
  output logic    zero
);

  logic  do_sub;
  word_t adder_b;
  word_t adder_sum;
  logic  adder_cout;
  logic  slt_bit;
  logic  sltu_bit;
  logic  [4:0] shamt;

  // sub, slt and sltu all need src1 - src2
  assign do_sub = (alu_op == `ALU_SUB) || (alu_op == `ALU_SLT) || (alu_op == `ALU_SLTU);
  assign adder_b = do_sub ? ~src2 : src2;
  // carry-in of one completes the two's complement
  assign {adder_cout, adder_sum} = {1'b0, src1} + {1'b0, adder_b} + {{`EX_XLEN{1'b0}}, do_sub};

  // negative vs positive decides directly
  // equal signs leave it to the sign of the difference
  assign slt_bit = (src1[`EX_XLEN-1] & ~src2[`EX_XLEN-1])
                 | (~(src1[`EX_XLEN-1] ^ src2[`EX_XLEN-1]) & adder_sum[`EX_XLEN-1]);
  // no carry out means a borrow
  assign sltu_bit = ~adder_cout;

  // only five bits of shift distance
  assign shamt = src2[4:0];

  always_comb begin
    case (alu_op)
      `ALU_ADD:  result = adder_sum;
      `ALU_SUB:  result = adder_sum;
      `ALU_SLT:  result = {{(`EX_XLEN-1){1'b0}}, slt_bit};
      `ALU_SLTU: result = {{(`EX_XLEN-1){1'b0}}, sltu_bit};
      `ALU_AND:  result = src1 & src2;
      `ALU_NOR:  result = ~(src1 | src2);
      `ALU_OR:   result = src1 | src2;
      `ALU_XOR:  result = src1 ^ src2;
      `ALU_SLL:  result = src1 << shamt;
      `ALU_SRL:  result = src1 >> shamt;
      `ALU_SRA:  result = $signed(src1) >>> shamt;
      // immediate already placed by decode
      `ALU_LUI:  result = src2;
      default:   result = '0;
    endcase
  end

  // flags for the branch resolver
  assign less = result[0];
  assign zero = ~(|result);

endmodule

`default_nettype wire

// ==== rtl/ex_divider.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_params.svh"

module ex_divider
  import ex_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  start,
  input  word_t dividend,
  input  word_t divisor,
  input  logic  is_unsigned,
  input  logic  use_mod,
  output logic  done,
  output word_t result
);

  localparam int CNT_W = $clog2(`DIV_STEPS);

  logic             running;
  logic [CNT_W-1:0] step_cnt;
  // quo starts as the dividend and takes quotient bits in at the bottom
  word_t            quo;
  word_t            rem;
  word_t            dvs;
  logic             neg_quo;
  logic             neg_rem;
  logic             want_mod;
  logic             div_zero;
  word_t            abs_dividend;
  word_t            abs_divisor;
  logic [`EX_XLEN:0]   shifted;
  logic [`EX_XLEN+1:0] trial;

  // magnitudes for signed operands
  assign abs_dividend = (!is_unsigned && dividend[`EX_XLEN-1]) ? -dividend : dividend;
  assign abs_divisor  = (!is_unsigned && divisor[`EX_XLEN-1]) ? -divisor : divisor;

  // bring down the next dividend bit and try the subtract
  assign shifted = {rem, quo[`EX_XLEN-1]};
  assign trial   = {1'b0, shifted} - {2'b0, dvs};

  always_ff @(posedge clk) begin
    if (reset) begin
      running  <= 1'b0;
      step_cnt <= '0;
      done     <= 1'b0;
    end else begin
      done <= 1'b0;
      if (start) begin
        running  <= 1'b1;
        step_cnt <= '0;
      end else if (running) begin
        step_cnt <= step_cnt + 1'b1;
        // done shows up the cycle after the last step
        if (step_cnt == CNT_W'(`DIV_STEPS - 1)) begin
          running <= 1'b0;
          done    <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      quo      <= abs_dividend;
      rem      <= '0;
      dvs      <= abs_divisor;
      // signs of quotient and remainder
      neg_quo  <= !is_unsigned && (dividend[`EX_XLEN-1] ^ divisor[`EX_XLEN-1]);
      neg_rem  <= !is_unsigned && dividend[`EX_XLEN-1];
      want_mod <= use_mod;
      div_zero <= (divisor == '0);
    end else if (running) begin
      if (trial[`EX_XLEN+1]) begin
        // a borrow keeps the partial remainder
        rem <= shifted[`EX_XLEN-1:0];
        quo <= {quo[`EX_XLEN-2:0], 1'b0};
      end else begin
        rem <= trial[`EX_XLEN-1:0];
        quo <= {quo[`EX_XLEN-2:0], 1'b1};
      end
    end
  end

  // sign fix-up on the final values
  // divide by zero leaves the dividend in rem already
  // most negative by -1 wraps back to itself on negate
  always_comb begin
    if (want_mod) begin
      result = neg_rem ? -rem : rem;
    end else if (div_zero) begin
      result = '1;
    end else begin
      result = neg_quo ? -quo : quo;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/ex_branch.sv ====
`timescale 1ns/1ns
`default_nettype none

module ex_branch
  import ex_pkg::*;
(
  input  br_ctl_t br,
  input  logic    less,
  input  logic    zero,
  input  word_t   pc,
  input  word_t   rj,
  input  word_t   imm,
  output logic    need_jump,
  output word_t   jump_target,
  output logic    pre_fail
);

  logic  less_ok;
  logic  zero_ok;
  word_t target_base;
  word_t target_offs;

  // an unused flag always passes
  assign less_ok = ~br.use_less | (less == br.need_less);
  assign zero_ok = ~br.use_zero | (zero == br.need_zero);

  assign need_jump = br.may_jump & less_ok & zero_ok;

  // jirl style uses rj and the rest are pc relative
  assign target_base = br.use_rj ? rj : pc;
  // word offset shifted up by two
  assign target_offs = {imm[$bits(word_t)-3:0], 2'b00};
  assign jump_target = target_base + target_offs;

  // predictor guessed the other way
  assign pre_fail = need_jump ^ br.pre_jump;

endmodule

`default_nettype wire

// ==== rtl/ex_lsu_align.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_params.svh"

module ex_lsu_align
  import ex_pkg::*;
(
  input  word_t      addr,
  input  mem_width_t width,
  input  logic       is_unsigned,
  input  word_t      store_data,
  input  word_t      rdata,
  output logic       ale,
  output strb_t      strb,
  output word_t      wdata,
  output word_t      load_word
);

  logic [1:0] offset;
  logic [4:0] shamt;
  word_t      rdata_low;

  // byte lane within the word
  assign offset = addr[1:0];
  assign shamt  = {offset, 3'b000};

  always_comb begin
    case (width)
      `MW_B: begin
        ale  = 1'b0;
        strb = strb_t'(4'b0001) << offset;
      end
      `MW_H: begin
        // halfword needs an even address
        ale  = offset[0];
        strb = strb_t'(4'b0011) << offset;
      end
      `MW_W: begin
        ale  = |offset;
        strb = '1;
      end
      default: begin
        ale  = 1'b0;
        strb = '0;
      end
    endcase
  end

  // store data moves up to its lane
  assign wdata = store_data << shamt;

  // loaded lane moves down to bit 0
  assign rdata_low = rdata >> shamt;

  always_comb begin
    case (width)
      `MW_B:   load_word = {{24{rdata_low[7] & ~is_unsigned}}, rdata_low[7:0]};
      `MW_H:   load_word = {{16{rdata_low[15] & ~is_unsigned}}, rdata_low[15:0]};
      default: load_word = rdata_low;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/ex_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_params.svh"

module ex_ctrl
  import ex_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         in_valid,
  input  ex_req_t      in_req,
  input  word_t        alu_result,
  input  logic         need_jump,
  input  word_t        jump_target,
  input  logic         pre_fail,
  input  logic         ale,
  input  strb_t        strb,
  input  word_t        wdata,
  input  word_t        load_word,
  input  logic         div_done,
  input  word_t        div_result,
  input  dcache_resp_t dc_resp,
  output ex_req_t      req_q,
  output word_t        mem_addr,
  output logic         div_start,
  output dcache_req_t  dc_req,
  output logic         busy,
  output logic         res_valid,
  output ex_res_t      res
);

  ex_state_t state;
  ex_req_t   req_r;
  ex_res_t   res_r;
  logic      issue;
  logic      is_mem;
  logic      is_br;

  assign issue = in_valid && (state == ST_IDLE);

  // units see the new request in its issue cycle and the held one after
  assign req_q = issue ? in_req : req_r;

  // effective address is src1 + imm
  assign mem_addr = req_q.src1 + req_q.imm;

  assign is_mem = (req_q.kind == `KIND_LD) || (req_q.kind == `KIND_ST);
  assign is_br  = (req_q.kind == `KIND_BR);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= ST_IDLE;
      div_start <= 1'b0;
    end else begin
      div_start <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (in_valid) begin
            if (req_q.kind == `KIND_DIV) begin
              state     <= ST_DIV;
              div_start <= 1'b1;
            end else if (is_mem && !ale) begin
              state <= ST_MEM_REQ;
            end else begin
              // alu, branch and misaligned access finish now
              state <= ST_DONE;
            end
          end
        end
        ST_DIV: begin
          if (div_done) begin
            state <= ST_DONE;
          end
        end
        ST_MEM_REQ: begin
          // store is complete once accepted
          if (dc_resp.ready) begin
            state <= (req_r.kind == `KIND_ST) ? ST_DONE : ST_MEM_DATA;
          end
        end
        ST_MEM_DATA: begin
          if (dc_resp.rvalid) begin
            state <= ST_DONE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      req_r <= in_req;
      // word only kept for alu and branch as the others fill in later
      if ((req_q.kind == `KIND_ALU) || is_br) begin
        res_r.result <= alu_result;
      end else begin
        res_r.result <= '0;
      end
      res_r.excp_ale    <= is_mem && ale;
      res_r.need_jump   <= is_br && need_jump;
      res_r.jump_target <= jump_target;
      res_r.pre_fail    <= is_br && pre_fail;
    end else if ((state == ST_DIV) && div_done) begin
      res_r.result <= div_result;
    end else if ((state == ST_MEM_DATA) && dc_resp.rvalid) begin
      // rdata is only good in the rvalid cycle
      res_r.result <= load_word;
    end
  end

  // request fields hold still while waiting for ready
  always_comb begin
    dc_req.valid = (state == ST_MEM_REQ);
    dc_req.we    = (req_r.kind == `KIND_ST);
    dc_req.addr  = mem_addr;
    dc_req.strb  = strb;
    dc_req.wdata = wdata;
  end

  assign busy      = (state != ST_IDLE);
  assign res_valid = (state == ST_DONE);
  assign res       = res_r;

endmodule

`default_nettype wire

// ==== rtl/ex_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module ex_stage
  import ex_pkg::*;
(
  input  logic         clk,
  input  logic         reset,
  input  logic         in_valid,
  input  ex_req_t      in_req,
  output logic         busy,
  output logic         res_valid,
  output ex_res_t      res,
  output dcache_req_t  dc_req,
  input  dcache_resp_t dc_resp
);

  ex_req_t req_q;
  word_t   mem_addr;
  word_t   alu_result;
  logic    less;
  logic    zero;
  logic    need_jump;
  word_t   jump_target;
  logic    pre_fail;
  logic    ale;
  strb_t   strb;
  word_t   wdata;
  word_t   load_word;
  logic    div_start;
  logic    div_done;
  word_t   div_result;

  // sequencing and result register
  ex_ctrl i_ctrl (
    .clk         (clk),
    .reset       (reset),
    .in_valid    (in_valid),
    .in_req      (in_req),
    .alu_result  (alu_result),
    .need_jump   (need_jump),
    .jump_target (jump_target),
    .pre_fail    (pre_fail),
    .ale         (ale),
    .strb        (strb),
    .wdata       (wdata),
    .load_word   (load_word),
    .div_done    (div_done),
    .div_result  (div_result),
    .dc_resp     (dc_resp),
    .req_q       (req_q),
    .mem_addr    (mem_addr),
    .div_start   (div_start),
    .dc_req      (dc_req),
    .busy        (busy),
    .res_valid   (res_valid),
    .res         (res)
  );

  ex_alu i_alu (
    .alu_op (req_q.alu_op),
    .src1   (req_q.src1),
    .src2   (req_q.src2),
    .result (alu_result),
    .less   (less),
    .zero   (zero)
  );

  // rj is the first source operand
  ex_branch i_branch (
    .br          (req_q.br),
    .less        (less),
    .zero        (zero),
    .pc          (req_q.pc),
    .rj          (req_q.src1),
    .imm         (req_q.imm),
    .need_jump   (need_jump),
    .jump_target (jump_target),
    .pre_fail    (pre_fail)
  );

  ex_divider i_divider (
    .clk         (clk),
    .reset       (reset),
    .start       (div_start),
    .dividend    (req_q.src1),
    .divisor     (req_q.src2),
    .is_unsigned (req_q.is_unsigned),
    .use_mod     (req_q.use_mod),
    .done        (div_done),
    .result      (div_result)
  );

  // store data is src2
  ex_lsu_align i_lsu_align (
    .addr        (mem_addr),
    .width       (req_q.mem_width),
    .is_unsigned (req_q.is_unsigned),
    .store_data  (req_q.src2),
    .rdata       (dc_resp.rdata),
    .ale         (ale),
    .strb        (strb),
    .wdata       (wdata),
    .load_word   (load_word)
  );

endmodule

`default_nettype wire

// ==== verif/ex_ref_model.svh ====
`ifndef EX_REF_MODEL_SVH
`define EX_REF_MODEL_SVH

// expected alu word straight from the function list
function automatic word_t model_alu(alu_op_t op, word_t a, word_t b);
  word_t r;
  case (op)
    `ALU_ADD:  r = a + b;
    `ALU_SUB:  r = a - b;
    `ALU_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    `ALU_SLTU: r = (a < b) ? 32'd1 : 32'd0;
    `ALU_AND:  r = a & b;
    `ALU_NOR:  r = ~(a | b);
    `ALU_OR:   r = a | b;
    `ALU_XOR:  r = a ^ b;
    `ALU_SLL:  r = a << b[4:0];
    `ALU_SRL:  r = a >> b[4:0];
    `ALU_SRA:  r = word_t'($signed(a) >>> b[4:0]);
    `ALU_LUI:  r = b;
    default:   r = '0;
  endcase
  return r;
endfunction

// branch outcome with flags taken from the compare word
function automatic ex_res_t model_branch(ex_req_t q);
  ex_res_t r;
  word_t   cmp;
  logic    less;
  logic    zero;
  cmp  = model_alu(q.alu_op, q.src1, q.src2);
  less = cmp[0];
  zero = (cmp == '0);
  r = '0;
  r.result    = cmp;
  r.need_jump = q.br.may_jump;
  if (q.br.use_less && (less != q.br.need_less)) begin
    r.need_jump = 1'b0;
  end
  if (q.br.use_zero && (zero != q.br.need_zero)) begin
    r.need_jump = 1'b0;
  end
  r.jump_target = (q.br.use_rj ? q.src1 : q.pc) + (q.imm << 2);
  // prediction wrong either way
  r.pre_fail = (r.need_jump != q.br.pre_jump);
  return r;
endfunction

function automatic word_t model_div(word_t a, word_t b, logic uns, logic mod);
  // divide by zero gives all ones or the dividend back
  if (b == '0) begin
    return mod ? a : '1;
  end
  if (uns) begin
    return mod ? (a % b) : (a / b);
  end
  // overflow case wraps to itself
  if ((a == 32'h8000_0000) && (b == '1)) begin
    return mod ? '0 : a;
  end
  return mod ? word_t'($signed(a) % $signed(b)) : word_t'($signed(a) / $signed(b));
endfunction

function automatic logic model_ale(mem_width_t w, word_t addr);
  if (w == `MW_H) begin
    return addr[0];
  end
  if (w == `MW_W) begin
    return (addr[1:0] != 2'b00);
  end
  return 1'b0;
endfunction

function automatic strb_t model_strb(mem_width_t w, word_t addr);
  case (w)
    `MW_B:   return strb_t'(4'b0001 << addr[1:0]);
    `MW_H:   return strb_t'(4'b0011 << addr[1:0]);
    default: return 4'b1111;
  endcase
endfunction

// byte lane moved down and then extended
function automatic word_t model_load(word_t mem, mem_width_t w, word_t addr, logic uns);
  word_t lane;
  lane = mem >> (8 * addr[1:0]);
  case (w)
    `MW_B:   return uns ? {24'b0, lane[7:0]} : {{24{lane[7]}}, lane[7:0]};
    `MW_H:   return uns ? {16'b0, lane[15:0]} : {{16{lane[15]}}, lane[15:0]};
    default: return lane;
  endcase
endfunction

// byte-wise write under strobes
function automatic word_t merge_store(word_t old, strb_t strb, word_t data);
  word_t r;
  r = old;
  for (int b = 0; b < 4; b++) begin
    if (strb[b]) begin
      r[8*b +: 8] = data[8*b +: 8];
    end
  end
  return r;
endfunction

`endif

// ==== verif/tb_ex_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "ex_params.svh"

module tb_ex_stage
  import ex_pkg::*;
();

  `include "ex_ref_model.svh"

  // op count over all tests sizes the watchdog
  localparam int N_OPS = 400 + 200 + 150 + 300 + 20;

  logic         clk;
  logic         reset;
  logic         in_valid;
  ex_req_t      in_req;
  logic         busy;
  logic         res_valid;
  ex_res_t      res;
  dcache_req_t  dc_req;
  dcache_resp_t dc_resp;

  // cache contents and the expected copy
  word_t        cache_mem [256];
  word_t        model_mem [256];
  dcache_req_t  cap_req;
  logic         cap_seen;
  // delays the cache picked for the last access
  int           acc_wait;
  int           data_wait;

  ex_stage i_dut (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_req    (in_req),
    .busy      (busy),
    .res_valid (res_valid),
    .res       (res),
    .dc_req    (dc_req),
    .dc_resp   (dc_resp)
  );

  always #10 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      abort_run("word mismatch");
    end
  endtask

  task automatic check_strb(input string name, input strb_t exp, input strb_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
      abort_run("strobe mismatch");
    end
  endtask

  task automatic check_res(input string name, input ex_res_t exp, input ex_res_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
      abort_run("result mismatch");
    end
  endtask

  // one op is an issue strobe and a count of cycles to the result strobe
  task automatic run_op(input ex_req_t q, output ex_res_t r, output int cycles,
                        output logic saw_dc);
    @(negedge clk);
    if (busy) begin
      abort_run("stage still busy when a new op was due");
    end
    cap_seen = 1'b0;
    in_valid = 1'b1;
    in_req   = q;
    cycles   = 0;
    saw_dc   = 1'b0;
    do begin
      @(negedge clk);
      in_valid = 1'b0;
      cycles++;
      if (dc_req.valid) begin
        saw_dc = 1'b1;
      end
      if (cycles > 100) begin
        abort_run("no result strobe within 100 cycles");
      end
    end while (!res_valid);
    if (!busy) begin
      abort_run("busy was low in the result cycle");
    end
    r = res;
  endtask

  task automatic test_alu();
    ex_req_t q;
    ex_res_t r;
    int      cyc;
    logic    saw;
    for (int i = 0; i < 400; i++) begin
      q = '0;
      q.kind   = `KIND_ALU;
      q.alu_op = alu_op_t'(i % 12);
      q.src1   = $urandom;
      q.src2   = ($urandom_range(0, 7) == 0) ? q.src1 : $urandom;
      run_op(q, r, cyc, saw);
      if (cyc != 1 || saw) begin
        abort_run($sformatf("alu op %0d took %0d cycles or touched the cache", i, cyc));
      end
      check_word($sformatf("alu %0d op %0d", i, q.alu_op),
                 model_alu(q.alu_op, q.src1, q.src2), r.result);
    end
  endtask

  task automatic test_branch();
    ex_req_t q;
    ex_res_t r;
    int      cyc;
    logic    saw;
    for (int i = 0; i < 200; i++) begin
      q = '0;
      q.kind   = `KIND_BR;
      // flags from sub, slt or sltu
      q.alu_op = alu_op_t'($urandom_range(1, 3));
      q.src1   = $urandom;
      q.src2   = ($urandom_range(0, 3) == 0) ? q.src1 : $urandom;
      q.imm    = $urandom;
      q.pc     = $urandom & 32'hffff_fffc;
      q.br     = br_ctl_t'($urandom_range(0, 127));
      run_op(q, r, cyc, saw);
      if (cyc != 1 || saw) begin
        abort_run($sformatf("branch %0d took %0d cycles or touched the cache", i, cyc));
      end
      check_res($sformatf("branch %0d", i), model_branch(q), r);
    end
  endtask

  task automatic test_div();
    ex_req_t q;
    ex_res_t r;
    int      cyc;
    logic    saw;
    for (int i = 0; i < 150; i++) begin
      q = '0;
      q.kind        = `KIND_DIV;
      q.src1        = $urandom;
      q.src2        = $urandom;
      q.is_unsigned = $urandom_range(0, 1) == 1;
      q.use_mod     = $urandom_range(0, 1) == 1;
      // corner cases mixed in
      if (i % 10 == 0) begin
        q.src2 = '0;
      end else if (i % 10 == 1) begin
        q.src1 = 32'h8000_0000;
        q.src2 = '1;
      end else if (i % 10 == 2) begin
        q.src2 = $urandom_range(1, 17);
      end
      run_op(q, r, cyc, saw);
      if (cyc != 35 || saw) begin
        abort_run($sformatf("divide %0d took %0d cycles or touched the cache", i, cyc));
      end
      check_word($sformatf("div %0d", i),
                 model_div(q.src1, q.src2, q.is_unsigned, q.use_mod), r.result);
    end
  endtask

  task automatic test_mem();
    ex_req_t q;
    ex_res_t r;
    int      cyc;
    logic    saw;
    word_t   addr;
    int      idx;
    for (int i = 0; i < 300; i++) begin
      q = '0;
      q.kind        = ($urandom_range(0, 1) == 1) ? `KIND_ST : `KIND_LD;
      q.mem_width   = mem_width_t'($urandom_range(0, 2));
      q.is_unsigned = $urandom_range(0, 1) == 1;
      q.src1        = $urandom;
      q.src2        = $urandom;
      q.imm         = $urandom_range(0, 1023);
      // pull the address back onto an aligned boundary
      addr = q.src1 + q.imm;
      if (q.mem_width == `MW_H) begin
        q.imm = q.imm - {31'b0, addr[0]};
      end else if (q.mem_width == `MW_W) begin
        q.imm = q.imm - {30'b0, addr[1:0]};
      end
      addr = q.src1 + q.imm;
      idx  = int'(addr[9:2]);
      run_op(q, r, cyc, saw);
      if (!saw || !cap_seen) begin
        abort_run($sformatf("memory op %0d made no cache request", i));
      end
      check_word($sformatf("mem %0d addr", i), addr, cap_req.addr);
      check_word($sformatf("mem %0d we", i), {31'b0, (q.kind == `KIND_ST)},
                 {31'b0, cap_req.we});
      check_word($sformatf("mem %0d ale", i), {31'b0, model_ale(q.mem_width, addr)},
                 {31'b0, r.excp_ale});
      if (q.kind == `KIND_ST) begin
        // request one cycle after issue and result one cycle after acceptance
        if (cyc != 2 + acc_wait) begin
          abort_run($sformatf("store %0d took %0d cycles with ready delayed %0d",
                              i, cyc, acc_wait));
        end
        check_strb($sformatf("store %0d strb", i), model_strb(q.mem_width, addr),
                   cap_req.strb);
        check_word($sformatf("store %0d wdata", i), q.src2 << (8 * addr[1:0]),
                   cap_req.wdata);
        model_mem[idx] = merge_store(model_mem[idx], model_strb(q.mem_width, addr),
                                     q.src2 << (8 * addr[1:0]));
      end else begin
        // rvalid comes at least one cycle after acceptance
        if (cyc != 3 + acc_wait + data_wait) begin
          abort_run($sformatf("load %0d took %0d cycles with delays %0d and %0d",
                              i, cyc, acc_wait, data_wait));
        end
        check_word($sformatf("load %0d", i),
                   model_load(model_mem[idx], q.mem_width, addr, q.is_unsigned), r.result);
      end
    end
  endtask

  task automatic test_misaligned();
    ex_req_t q;
    ex_res_t r;
    int      cyc;
    logic    saw;
    for (int i = 0; i < 20; i++) begin
      q = '0;
      q.kind      = (i % 2 == 0) ? `KIND_LD : `KIND_ST;
      q.mem_width = (i % 4 < 2) ? `MW_H : `MW_W;
      // odd address for halfwords and any nonzero offset for words
      q.src1 = ($urandom & 32'hffff_fffc) | ((q.mem_width == `MW_H) ? 32'd1 : 32'd0)
             | ((q.mem_width == `MW_W) ? word_t'($urandom_range(1, 3)) : 32'd0);
      q.src1 = q.src1 | {31'b0, (q.mem_width == `MW_H) & ($urandom_range(0, 1) == 1)} << 1;
      q.src2 = $urandom;
      run_op(q, r, cyc, saw);
      if (cyc != 1 || saw || cap_seen) begin
        abort_run($sformatf("misaligned op %0d took %0d cycles or reached the cache", i, cyc));
      end
      check_word($sformatf("ale %0d", i), {31'b0, model_ale(q.mem_width, q.src1)},
                 {31'b0, r.excp_ale});
    end
  endtask

  // data cache with random ready and rvalid delays
  initial begin : cache_responder
    int d;
    dc_resp = '0;
    forever begin
      @(negedge clk);
      dc_resp.ready  = 1'b0;
      dc_resp.rvalid = 1'b0;
      if (dc_req.valid && !reset) begin
        d = $urandom_range(0, 3);
        acc_wait = d;
        repeat (d) @(negedge clk);
        cap_req       = dc_req;
        cap_seen      = 1'b1;
        dc_resp.ready = 1'b1;
        @(negedge clk);
        dc_resp.ready = 1'b0;
        if (cap_req.we) begin
          cache_mem[cap_req.addr[9:2]] = merge_store(cache_mem[cap_req.addr[9:2]],
                                                     cap_req.strb, cap_req.wdata);
        end else begin
          d = $urandom_range(0, 3);
          data_wait = d;
          repeat (d) @(negedge clk);
          dc_resp.rvalid = 1'b1;
          dc_resp.rdata  = cache_mem[cap_req.addr[9:2]];
          @(negedge clk);
          dc_resp.rvalid = 1'b0;
          // junk outside the rvalid cycle
          dc_resp.rdata  = $urandom;
        end
      end
    end
  end

  initial begin : watchdog
    #((N_OPS * 60 + 200) * 20);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    void'($urandom(41));
    clk       = 1'b0;
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_req    = '0;
    cap_seen  = 1'b0;
    cap_req   = '0;
    acc_wait  = 0;
    data_wait = 0;
    // fill depends on every address bit
    for (int i = 0; i < 256; i++) begin
      cache_mem[i] = (32'h9e37_79b9 * (i + 1)) ^ {i[7:0], ~i[7:0], i[7:0], 8'h5a};
      model_mem[i] = cache_mem[i];
    end
    repeat (2) @(negedge clk);
    reset = 1'b0;
    if (res_valid || busy || dc_req.valid) begin
      abort_run("outputs not idle right after reset");
    end
    test_alu();
    test_branch();
    test_div();
    test_mem();
    test_misaligned();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+rtl
+incdir+verif
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_divider.sv
rtl/ex_branch.sv
rtl/ex_lsu_align.sv
rtl/ex_ctrl.sv
rtl/ex_stage.sv
verif/tb_ex_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard rtl/*) $(wildcard verif/*)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q -- '\*\* PASS \*\*'

clean:
	rm -rf $(OBJ_DIR)
